// File: Makefile
TOP := tb_frequency_meter

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

obj_dir/V$(TOP): project.f *.sv
	verilator --binary --timing -j 0 -f project.f --top-module $(TOP)

test: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

// File: edge_analyzer.sv
`timescale 1ns/1ps

module edge_analyzer
    import freq_meter_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   start,
    input  logic                   stop,
    input  logic                   edge_pulse,
    output logic [COUNT_WIDTH-1:0] count,
    output logic                   done
);

    logic start_q;
    logic stop_q;
    logic armed;
    logic start_fall;
    logic stop_rise;
    logic gate_open;
    logic [COUNT_WIDTH-1:0] running;

    assign start_fall = start_q & ~start;
    assign stop_rise  = stop & ~stop_q;

    // Open from the first cycle after start until stop rises
    assign gate_open = (armed | start_fall) & ~start & ~stop;

    //////////////////////////////
    // Gate control
    //////////////////////////////

    always_ff @(posedge clock)
    begin
        if (!reset)
        begin
            start_q <= 1'b0;
            stop_q  <= 1'b0;
            armed   <= 1'b0;
            done    <= 1'b0;
        end
        else
        begin
            start_q <= start;
            stop_q  <= stop;
            done    <= stop_rise;
            if (stop_rise)
                armed <= 1'b0;
            else if (start_fall)
                armed <= 1'b1;
        end
    end

    //////////////////////////////
    // Edge counting
    //////////////////////////////

    always_ff @(posedge clock)
    begin
        if (start)
            running <= '0;
        else if (gate_open && edge_pulse)
            running <= running + 1'b1;

        // Snapshot lines up with done on the next cycle
        if (stop_rise)
            count <= running;
    end

endmodule

// File: freq_meter_pkg.sv
package freq_meter_pkg;

    //////////////////////////////
    // Clock and gate timing
    //////////////////////////////

    localparam int CLOCK_HZ = 250_000_000;

    // Ticks per analyzer half-period
    localparam int GATE_TICKS = 104;

    // Length of each start or stop strobe
    localparam int SIGNAL_DELAY = 4;

    // Gate stays open between the end of start and the beginning of stop
    localparam int WINDOW_TICKS = GATE_TICKS - SIGNAL_DELAY;
    localparam int CYCLE_TICKS = 2 * GATE_TICKS + SIGNAL_DELAY + 1;

    // One counted edge in a window is worth this many hertz
    localparam int HZ_PER_EDGE = CLOCK_HZ / WINDOW_TICKS;

    //////////////////////////////
    // Datapath widths
    //////////////////////////////

    localparam int COUNT_WIDTH = 16;
    localparam int FREQ_WIDTH = 32;

    // Sequencer phases within one cycle
    typedef enum logic [2:0] {
        PHASE_START_0   = 3'd0,
        PHASE_OPEN_0    = 3'd1,
        PHASE_SWAP      = 3'd2,
        PHASE_OPEN_1    = 3'd3,
        PHASE_SWAP_BACK = 3'd4
    } phase_t;

endpackage

// File: frequency_meter.sv
`timescale 1ns/1ps

module frequency_meter
    import freq_meter_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  enable,
    input  logic                  signal_in,
    output logic [FREQ_WIDTH-1:0] frequency_hz,
    output logic                  analyzer_id,
    output logic                  result_valid
);

    logic edge_pulse;
    logic start_analyzer_0;
    logic stop_analyzer_0;
    logic start_analyzer_1;
    logic stop_analyzer_1;
    logic [COUNT_WIDTH-1:0] count_0;
    logic [COUNT_WIDTH-1:0] count_1;
    logic done_0;
    logic done_1;

    input_synchronizer u_input_synchronizer (
        .clock      (clock),
        .reset      (reset),
        .signal_in  (signal_in),
        .edge_pulse (edge_pulse)
    );

    gate_sequencer u_gate_sequencer (
        .clock            (clock),
        .reset            (reset),
        .enable           (enable),
        .start_analyzer_0 (start_analyzer_0),
        .stop_analyzer_0  (stop_analyzer_0),
        .start_analyzer_1 (start_analyzer_1),
        .stop_analyzer_1  (stop_analyzer_1)
    );

    // Two analyzers in alternating windows
    edge_analyzer u_edge_analyzer_0 (
        .clock      (clock),
        .reset      (reset),
        .start      (start_analyzer_0),
        .stop       (stop_analyzer_0),
        .edge_pulse (edge_pulse),
        .count      (count_0),
        .done       (done_0)
    );

    edge_analyzer u_edge_analyzer_1 (
        .clock      (clock),
        .reset      (reset),
        .start      (start_analyzer_1),
        .stop       (stop_analyzer_1),
        .edge_pulse (edge_pulse),
        .count      (count_1),
        .done       (done_1)
    );

    result_register u_result_register (
        .clock        (clock),
        .reset        (reset),
        .done_0       (done_0),
        .done_1       (done_1),
        .count_0      (count_0),
        .count_1      (count_1),
        .frequency_hz (frequency_hz),
        .analyzer_id  (analyzer_id),
        .result_valid (result_valid)
    );

endmodule

// File: gate_sequencer.sv
`timescale 1ns/1ps

module gate_sequencer
    import freq_meter_pkg::*;
(
    input  logic clock,
    input  logic reset,
    input  logic enable,
    output logic start_analyzer_0,
    output logic stop_analyzer_0,
    output logic start_analyzer_1,
    output logic stop_analyzer_1
);

    logic [$clog2(CYCLE_TICKS)-1:0] tick_count;
    int tick_value;
    phase_t phase;

    assign tick_value = int'(tick_count);

    //////////////////////////////
    // Free-running tick counter
    //////////////////////////////

    always_ff @(posedge clock)
    begin
        if (!reset)
            tick_count <= '0;
        else if (enable)
        begin
            if (tick_value == CYCLE_TICKS - 1)
                tick_count <= '0;
            else
                tick_count <= tick_count + 1'b1;
        end
    end

    //////////////////////////////
    // Phase decode
    //////////////////////////////

    always_comb
    begin
        if (tick_value < SIGNAL_DELAY)
            phase = PHASE_START_0;
        else if (tick_value < GATE_TICKS)
            phase = PHASE_OPEN_0;
        else if (tick_value < GATE_TICKS + SIGNAL_DELAY)
            phase = PHASE_SWAP;
        else if (tick_value < 2 * GATE_TICKS)
            phase = PHASE_OPEN_1;
        else
            phase = PHASE_SWAP_BACK;
    end

    //////////////////////////////
    // Registered strobes
    //////////////////////////////

    // Levels hold while disabled so no gate can close
    always_ff @(posedge clock)
    begin
        if (!reset)
        begin
            start_analyzer_0 <= 1'b0;
            stop_analyzer_0  <= 1'b0;
            start_analyzer_1 <= 1'b0;
            stop_analyzer_1  <= 1'b0;
        end
        else if (enable)
        begin
            start_analyzer_0 <= 1'b0;
            stop_analyzer_0  <= 1'b0;
            start_analyzer_1 <= 1'b0;
            stop_analyzer_1  <= 1'b0;
            case (phase)
                PHASE_START_0:
                    start_analyzer_0 <= 1'b1;
                PHASE_SWAP:
                begin
                    // Analyzer 0 closes as analyzer 1 opens
                    stop_analyzer_0  <= 1'b1;
                    start_analyzer_1 <= 1'b1;
                end
                PHASE_SWAP_BACK:
                begin
                    start_analyzer_0 <= 1'b1;
                    stop_analyzer_1  <= 1'b1;
                end
                default:
                    ;
            endcase
        end
    end

endmodule

// File: input_synchronizer.sv
`timescale 1ns/1ps

module input_synchronizer
(
    input  logic clock,
    input  logic reset,
    input  logic signal_in,
    output logic edge_pulse
);

    // Metastability chain
    logic sync_0;
    logic sync_1;

    // Previous synchronized level for edge detection
    logic sync_d;

    always_ff @(posedge clock)
    begin
        if (!reset)
        begin
            sync_0 <= 1'b0;
            sync_1 <= 1'b0;
            sync_d <= 1'b0;
        end
        else
        begin
            sync_0 <= signal_in;
            sync_1 <= sync_0;
            sync_d <= sync_1;
        end
    end

    // Registered pulse three cycles after the input rises
    always_ff @(posedge clock)
    begin
        if (!reset)
            edge_pulse <= 1'b0;
        else
            edge_pulse <= sync_1 & ~sync_d;
    end

endmodule

// File: project.f
freq_meter_pkg.sv
input_synchronizer.sv
gate_sequencer.sv
edge_analyzer.sv
result_register.sv
frequency_meter.sv
tb_clock_gen.sv
tb_frequency_meter.sv

// File: result_register.sv
`timescale 1ns/1ps

module result_register
    import freq_meter_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   done_0,
    input  logic                   done_1,
    input  logic [COUNT_WIDTH-1:0] count_0,
    input  logic [COUNT_WIDTH-1:0] count_1,
    output logic [FREQ_WIDTH-1:0]  frequency_hz,
    output logic                   analyzer_id,
    output logic                   result_valid
);

    logic                   done_any;
    logic [COUNT_WIDTH-1:0] count_sel;
    logic [FREQ_WIDTH-1:0]  scaled;

    assign done_any = done_0 | done_1;

    // Only one analyzer finishes at a time
    assign count_sel = done_1 ? count_1 : count_0;

    // Edges in the window times hertz per edge
    assign scaled = FREQ_WIDTH'(count_sel) * FREQ_WIDTH'(HZ_PER_EDGE);

    always_ff @(posedge clock)
    begin
        if (!reset)
        begin
            frequency_hz <= '0;
            analyzer_id  <= 1'b0;
            result_valid <= 1'b0;
        end
        else
        begin
            result_valid <= done_any;
            if (done_any)
            begin
                frequency_hz <= scaled;
                analyzer_id  <= done_1;
            end
        end
    end

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
(
    output logic clock,
    output logic reset
);

    localparam int HALF_PERIOD_NS = 2;
    localparam int RESET_CYCLES = 10;

    // 4 ns clock
    initial
    begin
        clock = 1'b0;
        forever
            #HALF_PERIOD_NS clock = ~clock;
    end

    // Active low reset released on a rising edge
    initial
    begin
        reset = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b1;
    end

endmodule

// File: tb_frequency_meter.sv
`timescale 1ns/1ps

module tb_frequency_meter
    import freq_meter_pkg::*;
();

    localparam int CLOCK_PERIOD_NS = 4;
    localparam int RANDOM_PERIODS = 8;
    localparam int TEST_WINDOWS = 4 * (2 + 3) + (2 + 2) + (1 + 3) + RANDOM_PERIODS * (2 + 2);
    localparam int MARGIN_NS = 10 * CYCLE_TICKS * CLOCK_PERIOD_NS;
    localparam int WATCHDOG_NS = TEST_WINDOWS * CYCLE_TICKS * CLOCK_PERIOD_NS + MARGIN_NS;
    localparam int HOLD_CYCLES = CYCLE_TICKS + 20;
    localparam logic [31:0] LFSR_SEED = 32'h3963;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic                  clock;
    logic                  reset;
    logic                  enable;
    logic                  signal_in;
    logic [FREQ_WIDTH-1:0] frequency_hz;
    logic                  analyzer_id;
    logic                  result_valid;

    // Period of the generated signal in cycles
    // Anything below 2 holds the signal low
    int signal_period = 0;
    int wave_count = 0;

    logic [31:0] lfsr_state = LFSR_SEED;
    logic        next_id = 1'b0;
    int          results_seen = 0;
    int          results_waited = 0;

    tb_clock_gen u_tb_clock_gen (
        .clock (clock),
        .reset (reset)
    );

    frequency_meter u_frequency_meter (
        .clock        (clock),
        .reset        (reset),
        .enable       (enable),
        .signal_in    (signal_in),
        .frequency_hz (frequency_hz),
        .analyzer_id  (analyzer_id),
        .result_valid (result_valid)
    );

    //////////////////////////////
    // Failure and compare tasks
    //////////////////////////////

    task automatic report_failure();
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_frequency(input logic [FREQ_WIDTH-1:0] actual,
                                   input logic [FREQ_WIDTH-1:0] expected);
        if (actual !== expected)
        begin
            $display("mismatch at %0t: frequency_hz got %0d expected %0d",
                     $time, actual, expected);
            report_failure();
        end
    endtask

    task automatic check_analyzer_id(input logic actual, input logic expected);
        if (actual !== expected)
        begin
            $display("mismatch at %0t: analyzer_id got %b expected %b",
                     $time, actual, expected);
            report_failure();
        end
    endtask

    task automatic check_result_valid(input logic actual, input logic expected);
        if (actual !== expected)
        begin
            $display("mismatch at %0t: result_valid got %b expected %b",
                     $time, actual, expected);
            report_failure();
        end
    endtask

    //////////////////////////////
    // Random numbers
    //////////////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] shifted;
        shifted = state >> 1;
        if (state[0])
            shifted = shifted ^ LFSR_TAPS;
        return shifted;
    endfunction

    // One LFSR step per bit taken
    task automatic take_random_bits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++)
        begin
            value = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    //////////////////////////////
    // Stimulus and monitors
    //////////////////////////////

    // Square wave that is high for the first half of each period
    initial
    begin
        signal_in = 1'b0;
        forever
        begin
            @(posedge clock);
            if (signal_period < 2)
            begin
                signal_in <= 1'b0;
                wave_count = 0;
            end
            else
            begin
                signal_in <= (wave_count < signal_period / 2);
                if (wave_count >= signal_period - 1)
                    wave_count = 0;
                else
                    wave_count = wave_count + 1;
            end
        end
    end

    // Every result must come from the other analyzer than the last one
    always @(negedge clock)
    begin
        if (reset === 1'b1 && result_valid === 1'b1)
        begin
            check_analyzer_id(analyzer_id, next_id);
            next_id = ~next_id;
            results_seen = results_seen + 1;
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired at %0t before the tests finished", $time);
        report_failure();
    end

    //////////////////////////////
    // Test helpers
    //////////////////////////////

    task automatic wait_for_result(output logic [FREQ_WIDTH-1:0] freq);
        int waited;
        bit found;
        waited = 0;
        found = 1'b0;
        freq = '0;
        while (!found && waited < CYCLE_TICKS)
        begin
            @(negedge clock);
            waited = waited + 1;
            if (result_valid === 1'b1)
            begin
                found = 1'b1;
                freq = frequency_hz;
            end
        end
        if (!found)
        begin
            $display("no result_valid within %0d cycles at %0t", CYCLE_TICKS, $time);
            report_failure();
        end
        results_waited = results_waited + 1;
    endtask

    // A window of 100 cycles holds floor or ceil of 100 / period edges
    task automatic check_period_result(input logic [FREQ_WIDTH-1:0] freq, input int period);
        int edges_low;
        int edges_high;
        logic [FREQ_WIDTH-1:0] hz_low;
        logic [FREQ_WIDTH-1:0] hz_high;
        if (period < 2)
        begin
            edges_low = 0;
            edges_high = 0;
        end
        else
        begin
            edges_low = WINDOW_TICKS / period;
            edges_high = edges_low;
            if (WINDOW_TICKS % period != 0)
                edges_high = edges_low + 1;
        end
        hz_low = FREQ_WIDTH'(edges_low * HZ_PER_EDGE);
        hz_high = FREQ_WIDTH'(edges_high * HZ_PER_EDGE);
        if (freq !== hz_high)
            check_frequency(freq, hz_low);
    endtask

    task automatic measure_period(input int period, input int checks);
        logic [FREQ_WIDTH-1:0] freq;
        // Change the signal right after a result
        wait_for_result(freq);
        signal_period = period;
        // Window in flight spans the change
        wait_for_result(freq);
        repeat (checks)
        begin
            wait_for_result(freq);
            check_period_result(freq, period);
        end
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////

    task automatic test_reset_state();
        @(negedge clock);
        check_result_valid(result_valid, 1'b0);
        check_frequency(frequency_hz, '0);
        check_analyzer_id(analyzer_id, 1'b0);
        repeat (GATE_TICKS - 1)
        begin
            @(negedge clock);
            check_result_valid(result_valid, 1'b0);
        end
    endtask

    task automatic test_fixed_periods();
        measure_period(2, 3);
        measure_period(4, 3);
        measure_period(10, 3);
        measure_period(25, 3);
    endtask

    task automatic test_constant_low();
        measure_period(0, 2);
    endtask

    task automatic test_enable_hold();
        logic [FREQ_WIDTH-1:0] freq;
        signal_period = 10;
        wait_for_result(freq);
        @(posedge clock);
        enable <= 1'b0;
        repeat (HOLD_CYCLES)
        begin
            @(negedge clock);
            check_result_valid(result_valid, 1'b0);
        end
        @(posedge clock);
        enable <= 1'b1;
        // First window after the hold opens cleanly
        repeat (3)
        begin
            wait_for_result(freq);
            check_period_result(freq, 10);
        end
    endtask

    task automatic test_random_periods();
        int value;
        int period;
        repeat (RANDOM_PERIODS)
        begin
            take_random_bits(6, value);
            period = 2 + (value % 39);
            measure_period(period, 2);
        end
    endtask

    initial
    begin
        enable = 1'b1;
        @(posedge reset);
        test_reset_state();
        test_fixed_periods();
        test_constant_low();
        test_enable_hold();
        test_random_periods();
        // Let the monitor see the last result
        @(negedge clock);
        if (results_seen == results_waited)
        begin
            $display("TESTBENCH PASSED");
            $finish;
        end
        else
        begin
            $display("monitor saw %0d results but the tests waited for %0d",
                     results_seen, results_waited);
            report_failure();
        end
    end

endmodule
